//--- files.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/inst_decode.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rename_stage.sv
verilog/rename_top.sv
sim/rename_assertions.sv
sim/rename_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rename front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module rename_tb \
  -Mdir obj_dir -o rename_sim

status=0
./obj_dir/rename_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation ok"

//--- sim/rename_assertions.sv
/* concurrent checks on the rename stage:
   station credits, ROB occupancy, no dispatch during rollback */
`default_nettype none
`include "rename_defines.svh"

module rename_assertions (
  input logic                                  clock,
  input logic                                  reset,
  input logic                                  dec_take,
  input logic                                  rollback_en,
  input logic                                  out_valid,
  input logic [$clog2(`OUT_CREDITS + 1)-1:0]   credits,
  input logic [$clog2(`NUM_ROB + 1)-1:0]       rob_count
);

  localparam int OW = $clog2(`NUM_ROB + 1);

  // packet leaves only if a credit was held at dispatch
  credit_held: assert property (@(posedge clock) disable iff (reset)
    out_valid |-> $past(credits) != '0)
    else $error("out_valid raised with no station credit held");

  rob_bound: assert property (@(posedge clock) disable iff (reset)
    rob_count <= OW'(`NUM_ROB))
    else $error("ROB occupancy above its depth");

  // rollback cycle restores the map, nothing may rename then
  no_take_on_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback_en |-> !dec_take)
    else $error("dispatch taken during a rollback");

endmodule

bind rename_stage rename_assertions checks_i (
  .clock       (clock),
  .reset       (reset),
  .dec_take    (dec_take),
  .rollback_en (rollback_en),
  .out_valid   (out_valid),
  .credits     (credits),
  .rob_count   (rob_count)
);

`default_nettype wire

//--- sim/rename_tb.sv
/* rename front end testbench: LFSR stimulus, reference model of map,
   ready bits, free list and ROB, field checks and closing summary */
`default_nettype none
`include "rename_defines.svh"

module rename_tb;

  localparam int STIM_CYCLES = 2000;
  localparam int TIMEOUT     = STIM_CYCLES + 500;  // stimulus plus drain room
  localparam rename_pkg::arch_idx_t ZERO = rename_pkg::arch_idx_t'(`ZERO_REG);

  typedef struct packed {
    logic                   in_valid;
    rename_pkg::inst_word_u word;
    rename_pkg::cdb_t       cdb;
    logic                   retire_en;
    logic                   retire_has_dest;
    rename_pkg::tag_t       retire_told;
    logic                   rollback_en;
    rename_pkg::rob_idx_t   rollback_idx;
    logic                   out_credit;
  } stim_t;

  typedef struct packed {
    rename_pkg::rob_idx_t  idx;
    rename_pkg::arch_idx_t dest;
    logic                  has_dest;
    rename_pkg::tag_t      dest_tag;
    rename_pkg::tag_t      told;
  } rob_ent_t;

  logic                     clock;
  logic                     reset;
  logic                     in_valid;
  rename_pkg::inst_word_u   in_word;
  logic [1:0]               in_credit;
  rename_pkg::cdb_t         cdb;
  logic                     retire_en;
  logic                     retire_has_dest;
  rename_pkg::tag_t         retire_told;
  logic                     rollback_en;
  rename_pkg::rob_idx_t     rollback_idx;
  logic                     out_credit;
  logic                     out_valid;
  rename_pkg::renamed_pkt_t out_pkt;

  // reference model state
  rename_pkg::tag_t     map_m [`NUM_ARCH];
  logic [`NUM_PHYS-1:0] ready_m;
  rename_pkg::tag_t     free_q [$];
  rob_ent_t             rob_q [$];
  logic [31:0]          word_q [$];        // words fetched and not yet renamed
  int                   return_at [$];     // cycles when station credits come back
  rename_pkg::rob_idx_t tail_m;
  stim_t                cur;
  stim_t                prev;              // inputs of the cycle being checked
  logic [31:0]          lfsr;
  int fetch_credits, station_credits, cycle, sent, renamed, flushed;
  int mismatches, failures;
  logic draining, done, timed_out;

  rename_top dut_i (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [31:0] make_word();
    logic [31:0] w;
    w = take_bits(32);
    if (take_bits(2) == 0) w[25:21] = ZERO;  // often no destination
    return w;
  endfunction

  function automatic logic ready_of(input rename_pkg::arch_idx_t a, input rename_pkg::cdb_t c);
    return (a == ZERO) || ready_m[map_m[a]] || (c.valid && c.tag == map_m[a]);
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string why);
    failures++;
    $display("FAILURE at %0t: %s", $time, why);
  endtask

  task automatic hold_idle();
    cur = '0;
    in_valid <= 1'b0;
    cdb <= '0;
    retire_en <= 1'b0;
    rollback_en <= 1'b0;
    out_credit <= 1'b0;
  endtask

  task automatic drive_inputs();
    stim_t s;
    int    k;
    s = '0;
    if (!draining && fetch_credits > 0 && take_bits(1) == 1) begin
      s.in_valid = 1'b1;
      s.word     = make_word();
      fetch_credits--;
      sent++;
    end
    if (rob_q.size() > 0 && take_bits(1) == 1) begin
      k = int'(take_bits(3)) % rob_q.size();
      s.cdb.valid = rob_q[k].has_dest;
      s.cdb.tag   = rob_q[k].dest_tag;
    end
    // control ops spaced so the model front is known
    if (!prev.retire_en && !prev.rollback_en && rob_q.size() > 0) begin
      if (!draining && take_bits(4) == 0) begin
        k = int'(take_bits(3)) % rob_q.size();
        s.rollback_en  = 1'b1;
        s.rollback_idx = rob_q[k].idx;
      end else if (take_bits(1) == 1) begin
        s.retire_en       = 1'b1;
        s.retire_has_dest = rob_q[0].has_dest;
        s.retire_told     = rob_q[0].told;
      end
    end
    for (k = 0; k < return_at.size(); k++) begin
      if (return_at[k] <= cycle) begin
        s.out_credit = 1'b1;
        return_at.delete(k);
        break;
      end
    end
    cur = s;
    in_valid        <= s.in_valid;
    in_word         <= s.word;
    cdb             <= s.cdb;
    retire_en       <= s.retire_en;
    retire_has_dest <= s.retire_has_dest;
    retire_told     <= s.retire_told;
    rollback_en     <= s.rollback_en;
    rollback_idx    <= s.rollback_idx;
    out_credit      <= s.out_credit;
  endtask

  // outputs seen now belong to the inputs of cycle p
  task automatic process_cycle(input stim_t p);
    logic [31:0]           w;
    logic                  is_i;
    logic                  hd;
    rename_pkg::arch_idx_t dst;
    rename_pkg::arch_idx_t sa;
    rename_pkg::arch_idx_t sb;
    rename_pkg::tag_t      new_tag;
    rob_ent_t              e;
    int                    exp_credit;
    // one slot per pop, and every held slot plus the dropped word on a flush
    exp_credit = int'(out_valid);
    if (p.rollback_en) exp_credit += word_q.size() + int'(p.in_valid);
    check("in_credit", 32'(in_credit), 32'(exp_credit));
    fetch_credits += int'(in_credit);
    if (out_valid) begin
      assert (station_credits > 0) else report_failure("packet sent with no station credit");
      assert (word_q.size() > 0) else report_failure("packet with no instruction outstanding");
      w    = (word_q.size() > 0) ? word_q.pop_front() : '0;
      is_i = w[31];
      dst  = w[25:21];
      sa   = w[20:16];
      sb   = is_i ? ZERO : w[15:11];
      hd   = (dst != ZERO);
      assert (!hd || free_q.size() > 0) else report_failure("model free list ran dry");
      new_tag = (hd && free_q.size() > 0) ? free_q[0] : '0;
      check("rob_idx", 32'(out_pkt.rob_idx), 32'(tail_m));
      check("opcode", 32'(out_pkt.opcode), 32'(w[31:26]));
      check("has_dest", 32'(out_pkt.has_dest), 32'(hd));
      check("dest_tag", 32'(out_pkt.dest_tag), 32'(new_tag));
      check("told_tag", 32'(out_pkt.told_tag), 32'(map_m[dst]));
      check("src_a tag", 32'(out_pkt.src_a.tag), 32'(map_m[sa]));
      check("src_a ready", 32'(out_pkt.src_a.ready), 32'(ready_of(sa, p.cdb)));
      check("src_b tag", 32'(out_pkt.src_b.tag), 32'(map_m[sb]));
      check("src_b ready", 32'(out_pkt.src_b.ready), 32'(ready_of(sb, p.cdb)));
      check("uses_b", 32'(out_pkt.uses_b), 32'(!is_i));
      check("imm", 32'(out_pkt.imm), is_i ? 32'(w[15:0]) : 32'h0);
      check("func", 32'(out_pkt.func), is_i ? 32'h0 : 32'(w[10:0]));
      e = '{idx: tail_m, dest: dst, has_dest: hd, dest_tag: new_tag, told: map_m[dst]};
      station_credits--;
      renamed++;
      return_at.push_back(cycle + 1 + int'(take_bits(3)));
    end
    if (p.cdb.valid) ready_m[p.cdb.tag] = 1'b1;
    if (out_valid) begin
      if (hd) begin
        void'(free_q.pop_front());
        ready_m[new_tag] = 1'b0;  // write wins over a same-tag completion
        map_m[dst]       = new_tag;
      end
      rob_q.push_back(e);
      tail_m++;
    end
    if (p.retire_en) begin
      e = rob_q.pop_front();
      if (e.has_dest) free_q.push_back(e.told);
    end
    if (p.rollback_en) begin
      // undo squashed entries youngest first
      while (rob_q.size() > 0 && rob_q[$].idx != p.rollback_idx) begin
        e = rob_q.pop_back();
        if (e.has_dest) begin
          map_m[e.dest] = e.told;
          free_q.push_front(e.dest_tag);
        end
      end
      tail_m  = p.rollback_idx + 1'b1;
      flushed += word_q.size() + int'(p.in_valid);
      word_q.delete();
    end else if (p.in_valid) begin
      word_q.push_back(p.word);
    end
    if (p.out_credit) station_credits++;
  endtask

  function automatic logic drained();
    return word_q.size() == 0 && !prev.in_valid && fetch_credits == `IN_DEPTH &&
           return_at.size() == 0 && station_credits == `OUT_CREDITS;
  endfunction

  initial begin
    lfsr = 32'h939f0800;
    reset = 1'b1;
    hold_idle();
    in_word = '0;
    retire_has_dest = 1'b0;
    retire_told = '0;
    rollback_idx = '0;
    for (int i = 0; i < `NUM_ARCH; i++) map_m[i] = rename_pkg::tag_t'(i);  // identity
    for (int i = `NUM_ARCH; i < `NUM_PHYS; i++) free_q.push_back(rename_pkg::tag_t'(i));
    ready_m = '1;
    tail_m = '0;
    fetch_credits = `IN_DEPTH;
    station_credits = `OUT_CREDITS;
    {cycle, sent, renamed, flushed, mismatches, failures} = '0;
    {draining, done, timed_out} = '0;
    prev = '0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    while (!done && !timed_out) begin
      @(posedge clock);
      cycle++;
      draining = (cycle > STIM_CYCLES);
      if (cycle >= TIMEOUT) timed_out = 1'b1;
      else if (draining && drained()) done = 1'b1;
      if (timed_out || done) hold_idle();
      else drive_inputs();
      @(negedge clock);
      process_cycle(prev);
      prev = cur;
    end
    assert (!timed_out) else report_failure("pipeline did not drain before the cycle limit");
    assert (sent == renamed + flushed) else report_failure("instructions lost or duplicated");
    $display("cycle %0d: %0d sent, %0d renamed, %0d flushed, %0d mismatches, %0d other errors",
             cycle, sent, renamed, flushed, mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/free_list.sv
/* circular queue of free physical tags,
   with a saved head per ROB entry for rollback */
`default_nettype none
`include "rename_defines.svh"

module free_list (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 alloc,
  output rename_pkg::tag_t     alloc_tag,
  output logic                 empty,
  input  logic                 release_en,
  input  rename_pkg::tag_t     release_tag,
  input  logic                 ckpt_en,
  input  rename_pkg::rob_idx_t ckpt_idx,
  input  logic                 restore_en,
  input  rename_pkg::rob_idx_t restore_idx
);

  localparam int DEPTH = `NUM_PHYS - `NUM_ARCH;  // tags not mapped at reset
  localparam int PW    = $clog2(DEPTH);

  rename_pkg::tag_t fifo [DEPTH];
  logic [PW-1:0]    ckpt_head [`NUM_ROB];  // head after each entry's allocation
  logic [PW-1:0]    head;
  logic [PW-1:0]    tail;
  logic [PW-1:0]    head_next;
  logic [PW-1:0]    tail_next;
  logic [PW-1:0]    restore_gap;
  logic [PW:0]      count;

  assign alloc_tag = fifo[head];
  assign empty     = (count == '0);
  assign head_next = head + PW'(alloc);
  assign tail_next = tail + PW'(release_en);

  // free tags between restored head and tail
  // a gap of 0 can only mean full: survivors hold at most NUM_ROB tags
  assign restore_gap = tail_next - ckpt_head[restore_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        fifo[i] <= rename_pkg::tag_t'(`NUM_ARCH + i);  // tags 32..63 in order
      end
    end else if (release_en) begin
      fifo[tail] <= release_tag;  // retired told tag goes to the back
    end
  end

  always_ff @(posedge clock) begin
    if (ckpt_en) begin
      ckpt_head[ckpt_idx] <= head_next;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= (PW+1)'(DEPTH);  // starts full
    end else begin
      tail <= tail_next;
      if (restore_en) begin
        // squashed allocations become free again
        head  <= ckpt_head[restore_idx];
        count <= {restore_gap == '0, restore_gap};
      end else begin
        head  <= head_next;
        count <= count - (PW+1)'(alloc) + (PW+1)'(release_en);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/inst_decode.sv
/* decode queue: splits fetch words into register fields on entry,
   holds them for rename and returns freed slots as fetch credits */
`default_nettype none
`include "rename_defines.svh"

module inst_decode (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     in_valid,
  input  rename_pkg::inst_word_u   in_word,
  input  logic                     flush,
  input  logic                     dec_take,
  output logic [1:0]               in_credit,
  output logic                     dec_valid,
  output rename_pkg::decoded_pkt_t dec_pkt
);

  localparam int PW = (`IN_DEPTH > 1) ? $clog2(`IN_DEPTH) : 1;
  localparam rename_pkg::arch_idx_t ZERO = rename_pkg::arch_idx_t'(`ZERO_REG);

  rename_pkg::decoded_pkt_t q_mem [`IN_DEPTH];
  rename_pkg::decoded_pkt_t new_pkt;
  logic [PW-1:0]            rd_ptr;
  logic [PW-1:0]            wr_ptr;
  logic [1:0]               count;     // occupied slots
  logic                     is_i;
  logic                     push;

  // decode through whichever view the opcode msb picks
  always_comb begin
    is_i             = in_word.r_fmt.opcode[5];
    new_pkt.opcode   = in_word.r_fmt.opcode;
    new_pkt.dest     = in_word.r_fmt.dest;
    new_pkt.src_a    = in_word.r_fmt.src_a;
    new_pkt.src_b    = is_i ? ZERO : in_word.r_fmt.src_b;
    new_pkt.uses_b   = !is_i;
    new_pkt.has_dest = (in_word.r_fmt.dest != ZERO);
    new_pkt.imm      = is_i ? in_word.i_fmt.imm : 16'd0;
    new_pkt.func     = is_i ? 11'd0 : in_word.r_fmt.func;
  end

  assign push      = in_valid && !flush;  // word arriving on rollback is dropped
  assign dec_valid = (count != 2'd0);
  assign dec_pkt   = q_mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (push) begin
      q_mem[wr_ptr] <= new_pkt;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      count     <= 2'd0;
      in_credit <= 2'd0;
    end else if (flush) begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      count     <= 2'd0;
      in_credit <= count + {1'b0, in_valid};  // every held slot plus the dropped word
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (dec_take) rd_ptr <= rd_ptr + 1'b1;
      count     <= count + {1'b0, push} - {1'b0, dec_take};
      in_credit <= {1'b0, dec_take};          // one slot back per pop
    end
  end

endmodule

`default_nettype wire

//--- verilog/map_table.sv
/* arch-to-physical map with per-tag ready bits,
   CDB bypass on lookup and a map checkpoint per ROB entry */
`default_nettype none
`include "rename_defines.svh"

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  input  rename_pkg::arch_idx_t lookup_a,
  input  rename_pkg::arch_idx_t lookup_b,
  input  rename_pkg::arch_idx_t lookup_dest,
  output rename_pkg::src_op_t   src_a,
  output rename_pkg::src_op_t   src_b,
  output rename_pkg::tag_t      told_tag,
  input  logic                  write_en,
  input  rename_pkg::arch_idx_t write_dest,
  input  rename_pkg::tag_t      write_tag,
  input  rename_pkg::rob_idx_t  ckpt_idx,
  input  rename_pkg::cdb_t      cdb,
  input  logic                  restore_en,
  input  rename_pkg::rob_idx_t  restore_idx
);

  localparam rename_pkg::arch_idx_t ZERO = rename_pkg::arch_idx_t'(`ZERO_REG);

  rename_pkg::tag_t [`NUM_ARCH-1:0] map;
  rename_pkg::tag_t [`NUM_ARCH-1:0] map_next;
  rename_pkg::tag_t [`NUM_ARCH-1:0] ckpt [`NUM_ROB];  // tags only, readiness lives in ready
  logic [`NUM_PHYS-1:0]             ready;            // indexed by physical tag
  logic                             do_write;

  // zero reg keeps its reset mapping forever
  assign do_write = write_en && (write_dest != ZERO);

  // source lookups
  assign src_a.tag = map[lookup_a];
  assign src_b.tag = map[lookup_b];

  // ready if already set, completing this cycle, or the zero reg
  assign src_a.ready = (lookup_a == ZERO) || ready[src_a.tag] ||
                       (cdb.valid && (cdb.tag == src_a.tag));
  assign src_b.ready = (lookup_b == ZERO) || ready[src_b.tag] ||
                       (cdb.valid && (cdb.tag == src_b.tag));

  assign told_tag = map[lookup_dest];  // old mapping for the ROB

  always_comb begin
    map_next = map;
    if (do_write) begin
      map_next[write_dest] = write_tag;
    end
  end

  // every dispatch snapshots the map including its own write
  always_ff @(posedge clock) begin
    if (write_en) begin
      ckpt[ckpt_idx] <= map_next;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_ARCH; i++) begin
        map[i] <= rename_pkg::tag_t'(i);  // identity map
      end
      ready <= '1;
    end else begin
      if (restore_en) begin
        map <= ckpt[restore_idx];  // no dispatch in a rollback cycle
      end else begin
        map <= map_next;
      end
      if (cdb.valid) begin
        ready[cdb.tag] <= 1'b1;
      end
      if (do_write) begin
        ready[write_tag] <= 1'b0;  // new tag waits for its producer
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/rename_defines.svh
/* size macros for the rename front end:
   register counts, ROB depth, zero register, queue depth and credits */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file
`define NUM_ARCH 32
`define ZERO_REG 31          // hardwired zero, never renamed

// physical registers, NUM_ARCH of them mapped at reset
`define NUM_PHYS 64

// reorder buffer entries, one map checkpoint each
`define NUM_ROB 8

// decode queue slots, also the credits fetch starts with
`define IN_DEPTH 2

// credits the reservation stations grant at reset
`define OUT_CREDITS 4

`endif

//--- verilog/rename_pkg.sv
/* shared types: register and tag indices, the instruction word union,
   decoded and renamed packets, completion bus */
`default_nettype none
`include "rename_defines.svh"

package rename_pkg;

  typedef logic [$clog2(`NUM_ARCH)-1:0] arch_idx_t;  // architectural reg number
  typedef logic [$clog2(`NUM_PHYS)-1:0] tag_t;       // physical tag
  typedef logic [$clog2(`NUM_ROB)-1:0]  rob_idx_t;   // ROB slot
  typedef logic [5:0]                   opcode_t;    // msb set means I-type

  // register-register view
  typedef struct packed {
    opcode_t     opcode;
    arch_idx_t   dest;
    arch_idx_t   src_a;
    arch_idx_t   src_b;
    logic [10:0] func;
  } r_fmt_t;

  // register-immediate view
  typedef struct packed {
    opcode_t     opcode;
    arch_idx_t   dest;
    arch_idx_t   src_a;
    logic [15:0] imm;
  } i_fmt_t;

  // opcode and dest sit in the same bits in both views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_word_u;

  typedef struct packed {
    opcode_t     opcode;
    arch_idx_t   dest;
    arch_idx_t   src_a;
    arch_idx_t   src_b;      // ZERO_REG on I-type
    logic        uses_b;
    logic        has_dest;   // dest != ZERO_REG
    logic [15:0] imm;
    logic [10:0] func;
  } decoded_pkt_t;

  typedef struct packed {
    tag_t tag;
    logic ready;
  } src_op_t;

  typedef struct packed {
    rob_idx_t    rob_idx;
    opcode_t     opcode;
    logic        has_dest;
    tag_t        dest_tag;   // zero when no dest
    tag_t        told_tag;   // previous mapping, freed at retire
    src_op_t     src_a;
    src_op_t     src_b;
    logic        uses_b;
    logic [15:0] imm;
    logic [10:0] func;
  } renamed_pkt_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } cdb_t;

endpackage

`default_nettype wire

//--- verilog/rename_stage.sv
/* rename: dispatch decision, ROB tail and occupancy, station credits,
   output register; holds the map table and free list */
`default_nettype none
`include "rename_defines.svh"

module rename_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dec_valid,
  input  rename_pkg::decoded_pkt_t dec_pkt,
  output logic                     dec_take,
  input  rename_pkg::cdb_t         cdb,
  input  logic                     retire_en,
  input  logic                     retire_has_dest,
  input  rename_pkg::tag_t         retire_told,
  input  logic                     rollback_en,
  input  rename_pkg::rob_idx_t     rollback_idx,
  input  logic                     out_credit,
  output logic                     out_valid,
  output rename_pkg::renamed_pkt_t out_pkt
);

  localparam int CW = $clog2(`OUT_CREDITS + 1);
  localparam int OW = $clog2(`NUM_ROB + 1);

  rename_pkg::rob_idx_t     rob_tail;
  rename_pkg::rob_idx_t     rob_head;   // oldest live entry
  rename_pkg::rob_idx_t     keep_gap;
  logic [OW-1:0]            rob_count;
  logic [OW-1:0]            keep_count;
  logic [CW-1:0]            credits;
  rename_pkg::src_op_t      src_a_op;
  rename_pkg::src_op_t      src_b_op;
  rename_pkg::tag_t         alloc_tag;
  rename_pkg::tag_t         told_tag;
  logic                     fl_empty;
  rename_pkg::renamed_pkt_t ren_pkt;

  assign dec_take = dec_valid && (!dec_pkt.has_dest || !fl_empty) &&
                    (credits != '0) && !rollback_en && (rob_count != OW'(`NUM_ROB));

  // entries up to rollback_idx survive, at least one so 0 means full
  assign keep_gap   = rollback_idx + 1'b1 - rob_head;
  assign keep_count = {keep_gap == '0, keep_gap};

  map_table map_i (
    .clock       (clock),
    .reset       (reset),
    .lookup_a    (dec_pkt.src_a),
    .lookup_b    (dec_pkt.src_b),
    .lookup_dest (dec_pkt.dest),
    .src_a       (src_a_op),
    .src_b       (src_b_op),
    .told_tag    (told_tag),
    .write_en    (dec_take),
    .write_dest  (dec_pkt.dest),
    .write_tag   (alloc_tag),
    .ckpt_idx    (rob_tail),
    .cdb         (cdb),
    .restore_en  (rollback_en),
    .restore_idx (rollback_idx)
  );

  free_list free_i (
    .clock       (clock),
    .reset       (reset),
    .alloc       (dec_take && dec_pkt.has_dest),
    .alloc_tag   (alloc_tag),
    .empty       (fl_empty),
    .release_en  (retire_en && retire_has_dest),
    .release_tag (retire_told),
    .ckpt_en     (dec_take),
    .ckpt_idx    (rob_tail),
    .restore_en  (rollback_en),
    .restore_idx (rollback_idx)
  );

  always_comb begin
    ren_pkt.rob_idx  = rob_tail;
    ren_pkt.opcode   = dec_pkt.opcode;
    ren_pkt.has_dest = dec_pkt.has_dest;
    ren_pkt.dest_tag = dec_pkt.has_dest ? alloc_tag : '0;
    ren_pkt.told_tag = told_tag;
    ren_pkt.src_a    = src_a_op;
    ren_pkt.src_b    = src_b_op;
    ren_pkt.uses_b   = dec_pkt.uses_b;
    ren_pkt.imm      = dec_pkt.imm;
    ren_pkt.func     = dec_pkt.func;
  end

  always_ff @(posedge clock) begin
    if (dec_take) out_pkt <= ren_pkt;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rob_tail  <= '0;
      rob_head  <= '0;
      rob_count <= '0;
      credits   <= CW'(`OUT_CREDITS);
      out_valid <= 1'b0;
    end else begin
      out_valid <= dec_take;  // a credit was in hand at dispatch
      credits   <= credits - CW'(dec_take) + CW'(out_credit);
      if (retire_en) rob_head <= rob_head + 1'b1;
      if (rollback_en) begin
        rob_tail  <= rollback_idx + 1'b1;
        rob_count <= keep_count - OW'(retire_en);
      end else begin
        if (dec_take) rob_tail <= rob_tail + 1'b1;
        rob_count <= rob_count + OW'(dec_take) - OW'(retire_en);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/rename_top.sv
/* rename front end top: decode queue feeding the rename stage */
`default_nettype none

module rename_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     in_valid,
  input  rename_pkg::inst_word_u   in_word,
  output logic [1:0]               in_credit,
  input  rename_pkg::cdb_t         cdb,
  input  logic                     retire_en,
  input  logic                     retire_has_dest,
  input  rename_pkg::tag_t         retire_told,
  input  logic                     rollback_en,
  input  rename_pkg::rob_idx_t     rollback_idx,
  input  logic                     out_credit,
  output logic                     out_valid,
  output rename_pkg::renamed_pkt_t out_pkt
);

  logic                     dec_valid;
  logic                     dec_take;
  rename_pkg::decoded_pkt_t dec_pkt;

  inst_decode decode_i (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .flush     (rollback_en),  // queued words are younger than any survivor
    .dec_take  (dec_take),
    .in_credit (in_credit),
    .dec_valid (dec_valid),
    .dec_pkt   (dec_pkt)
  );

  rename_stage rename_i (
    .clock           (clock),
    .reset           (reset),
    .dec_valid       (dec_valid),
    .dec_pkt         (dec_pkt),
    .dec_take        (dec_take),
    .cdb             (cdb),
    .retire_en       (retire_en),
    .retire_has_dest (retire_has_dest),
    .retire_told     (retire_told),
    .rollback_en     (rollback_en),
    .rollback_idx    (rollback_idx),
    .out_credit      (out_credit),
    .out_valid       (out_valid),
    .out_pkt         (out_pkt)
  );

endmodule

`default_nettype wire
